// File: board_status_pkg.sv
// core clock domain definitions for the board status logic
// ltssm codes follow the hard IP test_out_icm encoding (bits 4:0)
// the lane-active mask sits directly above the ltssm field

package board_status_pkg;

   // link status word layout
   localparam int ltssm_w  = 5;
   localparam int lane_w   = 4;                 // one led per lane
   localparam int status_w = lane_w + ltssm_w;  // {lane_active, ltssm_state}

   // ltssm states that light a led
   localparam logic [ltssm_w-1:0] ltssm_compliance = 5'b00011;  // polling.compliance
   localparam logic [ltssm_w-1:0] ltssm_l0         = 5'b01111;  // link up

   // heartbeat counter width
   // bit 25 at 125 MHz gives a blink of roughly a quarter second
   localparam int alive_cnt_w_default = 26;

endpackage

// File: mgmt_reg_pkg.sv
// management register map for the sfp+ control block
// one address bit selects between the two words, other addresses do not exist
// bit positions match the control/status word layout of the original
// management software, bit 0 of the link word stays zero

package mgmt_reg_pkg;

   localparam int data_w = 32;

   // word addresses
   localparam logic addr_ctrl_status = 1'b0;
   localparam logic addr_link        = 1'b1;  // read only

   // control and status word
   localparam int bit_phy_reset   = 0;   // read back only
   localparam int bit_sfp1_rate   = 1;   // high for >4.25 GBd
   localparam int bit_sfp2_rate   = 2;
   localparam int bit_sfp1_txdis  = 3;
   localparam int bit_sfp2_txdis  = 4;
   localparam int bit_lane1_pwrdn = 5;
   localparam int bit_lane2_pwrdn = 6;
   localparam int bit_sfp2_fault  = 7;   // status pins from here up
   localparam int bit_sfp1_fault  = 8;
   localparam int bit_sfp1_mod    = 9;
   localparam int bit_sfp2_mod    = 10;

   // writable field, bits 1..6
   localparam int ctrl_lsb = bit_sfp1_rate;
   localparam int ctrl_w   = bit_lane2_pwrdn - bit_sfp1_rate + 1;

   // link word, crossed status word starts here
   localparam int link_lsb = 2;

endpackage

// File: mgmt_if.sv
// management bus between the top level and the register block
// plain strobes, no wait states: every wr or rd is taken on the edge it is seen
// read data comes back one mm_clk cycle after rd, marked by rd_valid

`timescale 1ns/1ps

interface mgmt_if;

   logic                            wr;
   logic                            rd;
   logic                            addr;      // one word select bit
   logic [mgmt_reg_pkg::data_w-1:0] wdata;
   logic [mgmt_reg_pkg::data_w-1:0] rdata;
   logic                            rd_valid;

   modport host
   (
      output wr, rd, addr, wdata,
      input  rdata, rd_valid
   );

   modport target
   (
      input  wr, rd, addr, wdata,
      output rdata, rd_valid
   );

endinterface

// File: reset_bridge.sv
// reset synchronizers for the core and management clock domains
// both assert asynchronously and release on the second edge of their own clock
// local_rstn_ext does not reach the core reset (safe mode is fixed on)

`timescale 1ns/1ps

module reset_bridge
(
   input  logic clk_out_buf,
   input  logic mm_clk,
   input  logic pcie_rstn,
   input  logic local_rstn_ext,
   output logic any_rstn_rr,
   output logic mm_rstn_rr
);

   logic any_rstn_r;
   logic mm_rstn_r;

   // core domain, pcie reset only
   always_ff @(posedge clk_out_buf or negedge pcie_rstn)
   begin
      if (!pcie_rstn)
      begin
         any_rstn_r  <= 1'b0;
         any_rstn_rr <= 1'b0;
      end
      else
      begin
         any_rstn_r  <= 1'b1;
         any_rstn_rr <= any_rstn_r;
      end
   end

   // management domain
   always_ff @(posedge mm_clk or negedge local_rstn_ext)
   begin
      if (!local_rstn_ext)
      begin
         mm_rstn_r  <= 1'b0;
         mm_rstn_rr <= 1'b0;
      end
      else
      begin
         mm_rstn_r  <= 1'b1;
         mm_rstn_rr <= mm_rstn_r;
      end
   end

   // release must ripple through the chain in order
   a_core_chain_order: assert property (@(posedge clk_out_buf) !(any_rstn_rr && !any_rstn_r));
   a_mm_chain_order:   assert property (@(posedge mm_clk) !(mm_rstn_rr && !mm_rstn_r));

endmodule

// File: link_led_driver.sv
// board leds from the ltssm status, all registered once on clk_out_buf
// leds follow their inputs one cycle later and are dark during reset
// alive_led toggles every 2**(alive_cnt_w-1) cycles

`timescale 1ns/1ps

module link_led_driver
#(
   parameter int alive_cnt_w = board_status_pkg::alive_cnt_w_default
)
(
   input  logic                              clk_out_buf,
   input  logic                              any_rstn_rr,
   input  logic [board_status_pkg::ltssm_w-1:0] ltssm_state,
   input  logic [board_status_pkg::lane_w-1:0]  lane_active,
   input  logic                              gen2_speed,
   output logic                              alive_led,
   output logic                              comp_led,
   output logic                              l0_led,
   output logic [board_status_pkg::lane_w-1:0]  lane_active_led,
   output logic                              gen2_led
);

   logic [alive_cnt_w-1:0] alive_cnt;  // free running heartbeat

   always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
   begin
      if (!any_rstn_rr)
      begin
         alive_cnt <= '0;
         alive_led <= 1'b0;
      end
      else
      begin
         alive_cnt <= alive_cnt + 1'b1;
         alive_led <= alive_cnt[alive_cnt_w-1];  // msb, one cycle behind
      end
   end

   // ltssm decode
   always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
   begin
      if (!any_rstn_rr)
      begin
         comp_led        <= 1'b0;
         l0_led          <= 1'b0;
         lane_active_led <= '0;
         gen2_led        <= 1'b0;
      end
      else
      begin
         comp_led        <= (ltssm_state == board_status_pkg::ltssm_compliance);
         l0_led          <= (ltssm_state == board_status_pkg::ltssm_l0);
         lane_active_led <= lane_active;
         gen2_led        <= gen2_speed;  // speed flag straight from the core
      end
   end

   // the link cannot be in compliance and L0 at once
   a_led_exclusive: assert property (
      @(posedge clk_out_buf) disable iff (!any_rstn_rr)
      !(comp_led && l0_led));

endmodule

// File: ltssm_gray_crosser.sv
// moves the link status word from clk_out_buf to mm_clk through gray code
// exact only for values held stable over several mm_clk cycles
// latency 3 to 4 mm_clk cycles, no marker for new data
// multi-bit jumps of the input may show a transient mix of old and new

`timescale 1ns/1ps

module ltssm_gray_crosser
(
   input  logic                               clk_out_buf,
   input  logic                               any_rstn_rr,
   input  logic                               mm_clk,
   input  logic                               mm_rstn_rr,
   input  logic [board_status_pkg::status_w-1:0] status_in,
   output logic [board_status_pkg::status_w-1:0] status_out
);

   logic [board_status_pkg::status_w-1:0] gray_core;   // launch register
   logic [board_status_pkg::status_w-1:0] gray_sync1;  // first mm flop, may go metastable
   logic [board_status_pkg::status_w-1:0] gray_sync2;

   function automatic logic [board_status_pkg::status_w-1:0] gray_to_bin
   (
      input logic [board_status_pkg::status_w-1:0] gray
   );
      logic [board_status_pkg::status_w-1:0] bin;
      bin[board_status_pkg::status_w-1] = gray[board_status_pkg::status_w-1];
      for (int i = board_status_pkg::status_w - 2; i >= 0; i--)
      begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // core side, glitch free launch
   always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
   begin
      if (!any_rstn_rr)
         gray_core <= '0;
      else
         gray_core <= status_in ^ (status_in >> 1);
   end

   // mm side
   always_ff @(posedge mm_clk or negedge mm_rstn_rr)
   begin
      if (!mm_rstn_rr)
      begin
         gray_sync1 <= '0;
         gray_sync2 <= '0;
         status_out <= '0;
      end
      else
      begin
         gray_sync1 <= gray_core;
         gray_sync2 <= gray_sync1;
         status_out <= gray_to_bin(gray_sync2);
      end
   end

   // input held over the launch window of the last two core edges,
   // so the synchronized code moves by at most one bit
   a_gray_single_step: assert property (
      @(posedge mm_clk) disable iff (!mm_rstn_rr)
      (($past(status_in, 2) == $past(status_in, 3)) &&
       ($past(status_in, 3) == $past(status_in, 4))) |->
         ($countones(gray_sync2 ^ $past(gray_sync2)) <= 1));

endmodule

// File: sfp_ctrl_regs.sv
// sfp+ control and status registers on the management bus
// a write to the control word drives the pins from the same mm_clk edge
// the link word is read only, writes to it are dropped
// reads return data one cycle after rd with rd_valid high for one cycle

`timescale 1ns/1ps

module sfp_ctrl_regs
(
   input  logic                               mm_clk,
   input  logic                               mm_rstn_rr,
   mgmt_if.target                             bus,
   input  logic [board_status_pkg::status_w-1:0] link_status,
   input  logic                               phy_reset_n,
   input  logic                               sfp1_tx_fault,
   input  logic                               sfp2_tx_fault,
   input  logic                               sfp1_mod,
   input  logic                               sfp2_mod,
   output logic                               sfp1_rate_sel,
   output logic                               sfp2_rate_sel,
   output logic                               sfp1_tx_disable,
   output logic                               sfp2_tx_disable,
   output logic                               lane1_prwdn,
   output logic                               lane2_prwdn
);

   logic [mgmt_reg_pkg::ctrl_w-1:0] ctrl_q;       // bits 1..6 of the control word
   logic [mgmt_reg_pkg::data_w-1:0] status_word;
   logic [mgmt_reg_pkg::data_w-1:0] link_word;

   always_ff @(posedge mm_clk or negedge mm_rstn_rr)
   begin
      if (!mm_rstn_rr)
         ctrl_q <= '0;
      else if (bus.wr && (bus.addr == mgmt_reg_pkg::addr_ctrl_status))
         ctrl_q <= bus.wdata[mgmt_reg_pkg::ctrl_lsb +: mgmt_reg_pkg::ctrl_w];
   end

   // pin drive
   assign sfp1_rate_sel   = ctrl_q[mgmt_reg_pkg::bit_sfp1_rate - mgmt_reg_pkg::ctrl_lsb];
   assign sfp2_rate_sel   = ctrl_q[mgmt_reg_pkg::bit_sfp2_rate - mgmt_reg_pkg::ctrl_lsb];
   assign sfp1_tx_disable = ctrl_q[mgmt_reg_pkg::bit_sfp1_txdis - mgmt_reg_pkg::ctrl_lsb];
   assign sfp2_tx_disable = ctrl_q[mgmt_reg_pkg::bit_sfp2_txdis - mgmt_reg_pkg::ctrl_lsb];
   assign lane1_prwdn     = ctrl_q[mgmt_reg_pkg::bit_lane1_pwrdn - mgmt_reg_pkg::ctrl_lsb];
   assign lane2_prwdn     = ctrl_q[mgmt_reg_pkg::bit_lane2_pwrdn - mgmt_reg_pkg::ctrl_lsb];

   // read-back words, control bits taken from the pins themselves
   always_comb
   begin
      status_word = '0;
      status_word[mgmt_reg_pkg::bit_phy_reset]   = phy_reset_n;
      status_word[mgmt_reg_pkg::bit_sfp1_rate]   = sfp1_rate_sel;
      status_word[mgmt_reg_pkg::bit_sfp2_rate]   = sfp2_rate_sel;
      status_word[mgmt_reg_pkg::bit_sfp1_txdis]  = sfp1_tx_disable;
      status_word[mgmt_reg_pkg::bit_sfp2_txdis]  = sfp2_tx_disable;
      status_word[mgmt_reg_pkg::bit_lane1_pwrdn] = lane1_prwdn;
      status_word[mgmt_reg_pkg::bit_lane2_pwrdn] = lane2_prwdn;
      status_word[mgmt_reg_pkg::bit_sfp2_fault]  = sfp2_tx_fault;
      status_word[mgmt_reg_pkg::bit_sfp1_fault]  = sfp1_tx_fault;
      status_word[mgmt_reg_pkg::bit_sfp1_mod]    = sfp1_mod;
      status_word[mgmt_reg_pkg::bit_sfp2_mod]    = sfp2_mod;

      link_word = '0;
      link_word[mgmt_reg_pkg::link_lsb +: board_status_pkg::status_w] = link_status;
   end

   always_ff @(posedge mm_clk or negedge mm_rstn_rr)
   begin
      if (!mm_rstn_rr)
         bus.rd_valid <= 1'b0;
      else
         bus.rd_valid <= bus.rd;
   end

   always_ff @(posedge mm_clk)
   begin
      if (bus.rd)
         bus.rdata <= (bus.addr == mgmt_reg_pkg::addr_link) ? link_word : status_word;
   end

   // host never issues both strobes in one cycle
   a_no_wr_rd: assert property (
      @(posedge mm_clk) disable iff (!mm_rstn_rr)
      !(bus.wr && bus.rd));

endmodule

// File: sonic_board_top.sv
// board glue around the pcie/10g core: resets, leds, status crossing, sfp+ pins
// both clocks come from outside, no pll in here
// phy_reset_n follows local_rstn_ext without synchronization
// alive_cnt_w can be shortened for simulation

`timescale 1ns/1ps

module sonic_board_top
#(
   parameter int alive_cnt_w = board_status_pkg::alive_cnt_w_default
)
(
   input  logic                               clk_out_buf,
   input  logic                               mm_clk,
   input  logic                               pcie_rstn,
   input  logic                               local_rstn_ext,
   input  logic [board_status_pkg::ltssm_w-1:0]  ltssm_state,
   input  logic [board_status_pkg::lane_w-1:0]   lane_active,
   input  logic                               gen2_speed,
   input  logic                               mm_wr,
   input  logic                               mm_rd,
   input  logic                               mm_addr,
   input  logic [mgmt_reg_pkg::data_w-1:0]     mm_wdata,
   input  logic                               sfp1_tx_fault,
   input  logic                               sfp2_tx_fault,
   input  logic                               sfp1_mod,
   input  logic                               sfp2_mod,
   output logic [mgmt_reg_pkg::data_w-1:0]     mm_rdata,
   output logic                               mm_rd_valid,
   output logic                               alive_led,
   output logic                               comp_led,
   output logic                               l0_led,
   output logic [board_status_pkg::lane_w-1:0]   lane_active_led,
   output logic                               gen2_led,
   output logic                               phy_reset_n,
   output logic                               sfp1_rate_sel,
   output logic                               sfp2_rate_sel,
   output logic                               sfp1_tx_disable,
   output logic                               sfp2_tx_disable,
   output logic                               lane1_prwdn,
   output logic                               lane2_prwdn
);

   logic                                  any_rstn_rr;
   logic                                  mm_rstn_rr;
   logic [board_status_pkg::status_w-1:0] link_status_core;  // {lanes, ltssm}
   logic [board_status_pkg::status_w-1:0] link_status_mm;

   mgmt_if mgmt_bus ();

   assign mgmt_bus.wr    = mm_wr;
   assign mgmt_bus.rd    = mm_rd;
   assign mgmt_bus.addr  = mm_addr;
   assign mgmt_bus.wdata = mm_wdata;
   assign mm_rdata       = mgmt_bus.rdata;
   assign mm_rd_valid    = mgmt_bus.rd_valid;

   assign phy_reset_n      = local_rstn_ext;
   assign link_status_core = {lane_active, ltssm_state};

   reset_bridge reset_bridge_i
   (
      .clk_out_buf    (clk_out_buf),
      .mm_clk         (mm_clk),
      .pcie_rstn      (pcie_rstn),
      .local_rstn_ext (local_rstn_ext),
      .any_rstn_rr    (any_rstn_rr),
      .mm_rstn_rr     (mm_rstn_rr)
   );

   link_led_driver #(.alive_cnt_w(alive_cnt_w)) link_led_driver_i
   (
      .clk_out_buf     (clk_out_buf),
      .any_rstn_rr     (any_rstn_rr),
      .ltssm_state     (ltssm_state),
      .lane_active     (lane_active),
      .gen2_speed      (gen2_speed),
      .alive_led       (alive_led),
      .comp_led        (comp_led),
      .l0_led          (l0_led),
      .lane_active_led (lane_active_led),
      .gen2_led        (gen2_led)
   );

   ltssm_gray_crosser ltssm_gray_crosser_i
   (
      .clk_out_buf (clk_out_buf),
      .any_rstn_rr (any_rstn_rr),
      .mm_clk      (mm_clk),
      .mm_rstn_rr  (mm_rstn_rr),
      .status_in   (link_status_core),
      .status_out  (link_status_mm)
   );

   sfp_ctrl_regs sfp_ctrl_regs_i
   (
      .mm_clk          (mm_clk),
      .mm_rstn_rr      (mm_rstn_rr),
      .bus             (mgmt_bus.target),
      .link_status     (link_status_mm),
      .phy_reset_n     (phy_reset_n),
      .sfp1_tx_fault   (sfp1_tx_fault),
      .sfp2_tx_fault   (sfp2_tx_fault),
      .sfp1_mod        (sfp1_mod),
      .sfp2_mod        (sfp2_mod),
      .sfp1_rate_sel   (sfp1_rate_sel),
      .sfp2_rate_sel   (sfp2_rate_sel),
      .sfp1_tx_disable (sfp1_tx_disable),
      .sfp2_tx_disable (sfp2_tx_disable),
      .lane1_prwdn     (lane1_prwdn),
      .lane2_prwdn     (lane2_prwdn)
   );

endmodule

// File: tb_checker.sv
// watches the dut ports and compares them with values built from the board rules
// core outputs are checked on the falling clk_out_buf edge, mm outputs on falling mm_clk
// link word reads are only compared once the status has been stable for 6 core cycles

`timescale 1ns/1ps

module tb_checker
#(
   parameter int alive_cnt_w = 6
)
(
   input  logic                                 clk_out_buf,
   input  logic                                 mm_clk,
   input  logic                                 pcie_rstn,
   input  logic                                 local_rstn_ext,
   input  logic [board_status_pkg::ltssm_w-1:0] ltssm_state,
   input  logic [board_status_pkg::lane_w-1:0]  lane_active,
   input  logic                                 gen2_speed,
   input  logic                                 exp_comp,
   input  logic                                 exp_l0,
   input  logic                                 mm_wr,
   input  logic                                 mm_rd,
   input  logic                                 mm_addr,
   input  logic [mgmt_reg_pkg::data_w-1:0]      mm_wdata,
   input  logic                                 sfp1_tx_fault,
   input  logic                                 sfp2_tx_fault,
   input  logic                                 sfp1_mod,
   input  logic                                 sfp2_mod,
   input  logic [mgmt_reg_pkg::data_w-1:0]      mm_rdata,
   input  logic                                 mm_rd_valid,
   input  logic                                 alive_led,
   input  logic                                 comp_led,
   input  logic                                 l0_led,
   input  logic [board_status_pkg::lane_w-1:0]  lane_active_led,
   input  logic                                 gen2_led,
   input  logic                                 phy_reset_n,
   input  logic                                 sfp1_rate_sel,
   input  logic                                 sfp2_rate_sel,
   input  logic                                 sfp1_tx_disable,
   input  logic                                 sfp2_tx_disable,
   input  logic                                 lane1_prwdn,
   input  logic                                 lane2_prwdn,
   output int                                   err_cnt,
   output int                                   chk_cnt
);

   int                                    core_rel = 0;    // core edges since pcie_rstn rose
   int                                    mm_rel = 0;
   int                                    stable_cnt = 0;
   int                                    core_err = 0;
   int                                    core_chk = 0;
   int                                    mm_err = 0;
   int                                    mm_chk = 0;
   logic                                  core_seen = 1'b0;
   logic                                  mm_seen = 1'b0;
   logic                                  exp_rdv = 1'b0;
   logic                                  rdata_known = 1'b0;
   logic [alive_cnt_w-1:0]                live_cnt = '0;   // heartbeat model
   logic [7:0]                            exp_core = '0;   // {alive,comp,l0,lanes,gen2}
   logic [5:0]                            exp_pins = '0;   // {lane2,lane1,txdis2,txdis1,rate2,rate1}
   logic [board_status_pkg::status_w-1:0] link_q = '0;
   logic [mgmt_reg_pkg::data_w-1:0]       exp_rdata = '0;
   string                                 exp_what = "status word";

   assign err_cnt = core_err + mm_err;
   assign chk_cnt = core_chk + mm_chk;

   function automatic int report_mismatch
   (
      input string                           what,
      input logic [mgmt_reg_pkg::data_w-1:0] got,
      input logic [mgmt_reg_pkg::data_w-1:0] exp
   );
      if (got === exp)
         return 0;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      return 1;
   endfunction

   // core domain model, live from the third edge after release
   always @(posedge clk_out_buf)
   begin
      if (core_rel >= 2)
      begin
         exp_core   = {live_cnt[alive_cnt_w-1], exp_comp, exp_l0, lane_active, gen2_speed};
         live_cnt   = live_cnt + 1'b1;
         stable_cnt = ({lane_active, ltssm_state} == link_q) ? stable_cnt + 1 : 0;
      end
      else
      begin
         exp_core   = '0;
         live_cnt   = '0;
         stable_cnt = 0;
      end
      link_q    = {lane_active, ltssm_state};
      core_rel  = !pcie_rstn ? 0 : ((core_rel < 2) ? core_rel + 1 : core_rel);
      core_seen = 1'b1;
   end

   always @(negedge clk_out_buf)
   begin
      if (core_seen)
      begin
         core_chk = core_chk + 1;
         core_err = core_err + report_mismatch("leds {alive,comp,l0,lanes,gen2}",
            {24'h0, alive_led, comp_led, l0_led, lane_active_led, gen2_led}, {24'h0, exp_core});
      end
   end

   // mm domain model of the register block
   always @(posedge mm_clk)
   begin
      exp_rdv = 1'b0;
      if (mm_rel >= 2)
      begin
         exp_rdv = mm_rd;
         if (mm_rd && (mm_addr == mgmt_reg_pkg::addr_link))
         begin
            exp_rdata   = '0;
            exp_rdata[mgmt_reg_pkg::link_lsb +: board_status_pkg::status_w] =
               {lane_active, ltssm_state};
            exp_what    = "link word";
            rdata_known = (stable_cnt >= 6);  // crossing settled
         end
         else if (mm_rd)
         begin
            exp_rdata = '0;
            exp_rdata[mgmt_reg_pkg::bit_phy_reset]   = local_rstn_ext;
            exp_rdata[mgmt_reg_pkg::bit_sfp1_rate]   = exp_pins[0];
            exp_rdata[mgmt_reg_pkg::bit_sfp2_rate]   = exp_pins[1];
            exp_rdata[mgmt_reg_pkg::bit_sfp1_txdis]  = exp_pins[2];
            exp_rdata[mgmt_reg_pkg::bit_sfp2_txdis]  = exp_pins[3];
            exp_rdata[mgmt_reg_pkg::bit_lane1_pwrdn] = exp_pins[4];
            exp_rdata[mgmt_reg_pkg::bit_lane2_pwrdn] = exp_pins[5];
            exp_rdata[mgmt_reg_pkg::bit_sfp2_fault]  = sfp2_tx_fault;
            exp_rdata[mgmt_reg_pkg::bit_sfp1_fault]  = sfp1_tx_fault;
            exp_rdata[mgmt_reg_pkg::bit_sfp1_mod]    = sfp1_mod;
            exp_rdata[mgmt_reg_pkg::bit_sfp2_mod]    = sfp2_mod;
            exp_what    = "status word";
            rdata_known = 1'b1;
         end
         if (mm_wr && (mm_addr == mgmt_reg_pkg::addr_ctrl_status))
            exp_pins = {mm_wdata[mgmt_reg_pkg::bit_lane2_pwrdn],
                        mm_wdata[mgmt_reg_pkg::bit_lane1_pwrdn],
                        mm_wdata[mgmt_reg_pkg::bit_sfp2_txdis],
                        mm_wdata[mgmt_reg_pkg::bit_sfp1_txdis],
                        mm_wdata[mgmt_reg_pkg::bit_sfp2_rate],
                        mm_wdata[mgmt_reg_pkg::bit_sfp1_rate]};
      end
      else
         exp_pins = '0;
      mm_rel  = !local_rstn_ext ? 0 : ((mm_rel < 2) ? mm_rel + 1 : mm_rel);
      mm_seen = 1'b1;
   end

   always @(negedge mm_clk)
   begin
      if (mm_seen)
      begin
         mm_chk = mm_chk + 1;
         mm_err = mm_err + report_mismatch("pins {phy_reset_n,ctrl pins,rd_valid}",
            {24'h0, phy_reset_n, lane2_prwdn, lane1_prwdn, sfp2_tx_disable, sfp1_tx_disable,
             sfp2_rate_sel, sfp1_rate_sel, mm_rd_valid},
            {24'h0, local_rstn_ext, exp_pins, exp_rdv});
         if (exp_rdv && rdata_known)
         begin
            mm_chk = mm_chk + 1;
            mm_err = mm_err + report_mismatch(exp_what, mm_rdata, exp_rdata);
         end
      end
   end

endmodule

// File: tb_sonic_board_top.sv
// testbench for sonic_board_top with the heartbeat shortened to 6 bits
// both clocks run at 20 ns, mm_clk half a period behind clk_out_buf
// each table row is held 12 cycles, the bus strobe comes in cycle 8 of a row

`timescale 1ns/1ps

module tb_sonic_board_top;

   typedef struct packed
   {
      logic [4:0]  ltssm;
      logic [3:0]  lanes;
      logic        gen2;
      logic [3:0]  pins;   // {sfp2_mod, sfp1_mod, sfp2_fault, sfp1_fault}
      logic [1:0]  op;
      logic        addr;
      logic [31:0] wdata;
      logic        rnd;    // wdata from xorshift instead
      logic        comp;   // expected comp_led
      logic        l0;     // expected l0_led
   } row_t;

   localparam int         n_rows      = 10;
   localparam int         hold_cycles = 12;
   localparam int         cycle_limit = n_rows * hold_cycles + 200;
   localparam logic [1:0] op_none     = 2'd0;
   localparam logic [1:0] op_wr       = 2'd1;
   localparam logic [1:0] op_rd       = 2'd2;
   localparam logic [4:0] st_comp     = board_status_pkg::ltssm_compliance;
   localparam logic [4:0] st_l0       = board_status_pkg::ltssm_l0;

   logic                                 clk_out_buf = 1'b0;
   logic                                 mm_clk = 1'b1;
   logic                                 pcie_rstn;
   logic                                 local_rstn_ext;
   logic [board_status_pkg::ltssm_w-1:0] ltssm_state;
   logic [board_status_pkg::lane_w-1:0]  lane_active;
   logic                                 gen2_speed;
   logic                                 mm_wr;
   logic                                 mm_rd;
   logic                                 mm_addr;
   logic [mgmt_reg_pkg::data_w-1:0]      mm_wdata;
   logic                                 sfp1_tx_fault;
   logic                                 sfp2_tx_fault;
   logic                                 sfp1_mod;
   logic                                 sfp2_mod;
   logic [mgmt_reg_pkg::data_w-1:0]      mm_rdata;
   logic                                 mm_rd_valid;
   logic                                 alive_led;
   logic                                 comp_led;
   logic                                 l0_led;
   logic [board_status_pkg::lane_w-1:0]  lane_active_led;
   logic                                 gen2_led;
   logic                                 phy_reset_n;
   logic                                 sfp1_rate_sel;
   logic                                 sfp2_rate_sel;
   logic                                 sfp1_tx_disable;
   logic                                 sfp2_tx_disable;
   logic                                 lane1_prwdn;
   logic                                 lane2_prwdn;
   logic                                 exp_comp;
   logic                                 exp_l0;
   int                                   err_cnt;
   int                                   chk_cnt;
   int                                   cycle_cnt = 0;
   logic [31:0]                          rnd_state;
   row_t                                 rows [n_rows];

   always #10 clk_out_buf = ~clk_out_buf;
   always #10 mm_clk = ~mm_clk;

   sonic_board_top #(.alive_cnt_w(6)) sonic_board_top_i (.*);

   tb_checker #(.alive_cnt_w(6)) tb_checker_i (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // one row: inputs at cycle 0, bus strobe at cycle 8, status readback at 9 after a write
   task automatic apply_row(input row_t r);
      logic [31:0] wdata;
      wdata = r.wdata;
      if (r.rnd)
      begin
         rnd_state = xorshift32(rnd_state);
         wdata     = rnd_state;
      end
      @(posedge clk_out_buf);
      #2;
      ltssm_state   = r.ltssm;
      lane_active   = r.lanes;
      gen2_speed    = r.gen2;
      exp_comp      = r.comp;
      exp_l0        = r.l0;
      sfp1_tx_fault = r.pins[0];
      sfp2_tx_fault = r.pins[1];
      sfp1_mod      = r.pins[2];
      sfp2_mod      = r.pins[3];
      for (int c = 1; c < hold_cycles; c++)
      begin
         @(posedge clk_out_buf);
         #2;
         mm_wr = 1'b0;
         mm_rd = 1'b0;
         if ((c == 8) && (r.op == op_wr))
         begin
            mm_wr    = 1'b1;
            mm_addr  = r.addr;
            mm_wdata = wdata;
         end
         else if ((c == 8) && (r.op == op_rd))
         begin
            mm_rd   = 1'b1;
            mm_addr = r.addr;
         end
         else if ((c == 9) && (r.op == op_wr))
         begin
            mm_rd   = 1'b1;
            mm_addr = mgmt_reg_pkg::addr_ctrl_status;
         end
      end
   endtask

   always @(posedge clk_out_buf)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial
   begin
      pcie_rstn      = 1'b0;
      local_rstn_ext = 1'b0;
      ltssm_state    = '0;
      lane_active    = '0;
      gen2_speed     = 1'b0;
      exp_comp       = 1'b0;
      exp_l0         = 1'b0;
      mm_wr          = 1'b0;
      mm_rd          = 1'b0;
      mm_addr        = 1'b0;
      mm_wdata       = '0;
      sfp1_tx_fault  = 1'b0;
      sfp2_tx_fault  = 1'b0;
      sfp1_mod       = 1'b0;
      sfp2_mod       = 1'b0;
      rnd_state      = 32'd37;
      //           ltssm    lanes gen2  pins     op     addr  wdata          rnd   comp  l0
      rows[0] = '{5'h00,   4'h0, 1'b0, 4'b0000, op_rd, 1'b0, 32'h0000_0000, 1'b0, 1'b0, 1'b0};
      rows[1] = '{st_comp, 4'h3, 1'b0, 4'b0011, op_wr, 1'b0, 32'h0000_007e, 1'b0, 1'b1, 1'b0};
      rows[2] = '{st_comp, 4'h3, 1'b1, 4'b0101, op_rd, 1'b1, 32'h0000_0000, 1'b0, 1'b1, 1'b0};
      rows[3] = '{st_l0,   4'hf, 1'b1, 4'b1010, op_rd, 1'b1, 32'h0000_0000, 1'b0, 1'b0, 1'b1};
      rows[4] = '{st_l0,   4'hf, 1'b1, 4'b1111, op_wr, 1'b1, 32'hffff_ffff, 1'b0, 1'b0, 1'b1};
      rows[5] = '{st_l0,   4'h5, 1'b0, 4'b0000, op_wr, 1'b0, 32'h0000_0000, 1'b1, 1'b0, 1'b1};
      rows[6] = '{5'h02,   4'ha, 1'b1, 4'b1100, op_rd, 1'b1, 32'h0000_0000, 1'b0, 1'b0, 1'b0};
      rows[7] = '{5'h1f,   4'h8, 1'b1, 4'b1001, op_wr, 1'b0, 32'h0000_0000, 1'b1, 1'b0, 1'b0};
      rows[8] = '{5'h0c,   4'h6, 1'b0, 4'b0111, op_rd, 1'b1, 32'h0000_0000, 1'b0, 1'b0, 1'b0};
      rows[9] = '{5'h00,   4'h0, 1'b0, 4'b0000, op_wr, 1'b0, 32'h0000_0000, 1'b0, 1'b0, 1'b0};

      repeat (4) @(posedge clk_out_buf);
      #2;
      pcie_rstn      = 1'b1;
      local_rstn_ext = 1'b1;
      repeat (4) @(posedge clk_out_buf);
      for (int i = 0; i < n_rows; i++)
         apply_row(rows[i]);
      repeat (4) @(posedge clk_out_buf);

      $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
      if ((err_cnt == 0) && (chk_cnt > 0))
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: build.f
board_status_pkg.sv
mgmt_reg_pkg.sv
mgmt_if.sv
reset_bridge.sv
link_led_driver.sv
ltssm_gray_crosser.sv
sfp_ctrl_regs.sv
sonic_board_top.sv
tb_checker.sv
tb_sonic_board_top.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -f build.f --top-module tb_sonic_board_top \
   -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "^PASS: all tests$" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }
